//--- Makefile
SIM       := verilator
FLAGS     := --binary --timing -j 0
TOP       := tb_wrsp_bank
FILELIST  := verilog.f
BUILD_DIR := obj_dir
LOG       := sim.log
FAIL_MSG  := Regression failed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); exit $$status
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "Simulation reported a failure, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- hw/wrsp_bank.sv
// Top level of the write-response bank, connects allocator, ID lists, release arbiter and RAM
`timescale 1ns/100ps

module wrsp_bank
  import wrsp_bank_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_ni,

  // Reservation
  input  id_t        res_id_i,
  input  logic       res_ready_i,
  output logic       res_valid_o,
  output slot_t      res_addr_o,

  // Response input
  input  msg_t       data_i,
  input  logic       in_valid_i,
  output logic       in_ready_o,

  // Release
  input  slot_mask_t release_en_i,
  output msg_t       data_o,
  output logic       out_valid_o,
  input  logic       out_ready_i,
  output slot_mask_t released_o
);

  logic              res_fire;
  logic              fill_we;
  slot_t             fill_slot;
  rel_sel_t          rel_sel;
  logic              rd_en;
  slot_t             rd_slot;
  slot_t [NumIds-1:0] tails;
  logic  [NumIds-1:0] has_filled;

  // Shared by the allocator and the lists
  assign res_fire = res_valid_o && res_ready_i;

  wrsp_slot_alloc wrsp_slot_alloc_inst (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .res_fire_i  (res_fire),
    .released_i  (released_o),
    .free_slot_o (res_addr_o),
    .any_free_o  (res_valid_o)
  );

  wrsp_id_lists wrsp_id_lists_inst (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .res_fire_i   (res_fire),
    .res_id_i     (res_id_i),
    .res_slot_i   (res_addr_o),
    .in_valid_i   (in_valid_i),
    .in_id_i      (data_i.id),
    .in_ready_o   (in_ready_o),
    .fill_we_o    (fill_we),
    .fill_slot_o  (fill_slot),
    .rel_sel_i    (rel_sel),
    .tails_o      (tails),
    .has_filled_o (has_filled)
  );

  wrsp_release_arbiter wrsp_release_arbiter_inst (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .tails_i      (tails),
    .has_filled_i (has_filled),
    .release_en_i (release_en_i),
    .out_ready_i  (out_ready_i),
    .rel_sel_o    (rel_sel),
    .rd_en_o      (rd_en),
    .rd_slot_o    (rd_slot),
    .out_valid_o  (out_valid_o),
    .released_o   (released_o)
  );

  wrsp_slot_ram wrsp_slot_ram_inst (
    .clk_i   (clk_i),
    .we_i    (fill_we),
    .waddr_i (fill_slot),
    .wdata_i (data_i),
    .re_i    (rd_en),
    .raddr_i (rd_slot),
    .rdata_o (data_o)
  );

endmodule

//--- hw/wrsp_bank_pkg.sv
// Shared widths, counts and packed types of the write-response bank, imported by every bank module
package wrsp_bank_pkg;

  // Response ID width and the number of IDs it gives
  localparam int IdWidth = 2;
  localparam int NumIds = 2 ** IdWidth;

  // Total slot capacity shared by all IDs
  localparam int NumSlots = 16;
  localparam int SlotWidth = $clog2(NumSlots);

  // Message body bits above the ID field
  localparam int PayloadWidth = 14;

  typedef logic [IdWidth-1:0] id_t;
  typedef logic [SlotWidth-1:0] slot_t;

  // One bit per slot, used for enables, occupancy and the released report
  typedef logic [NumSlots-1:0] slot_mask_t;

  // Response message, ID sits in the low bits
  typedef struct packed {
    logic [PayloadWidth-1:0] payload;
    id_t                     id;
  } msg_t;

  // ID and slot picked for release in the current cycle
  typedef struct packed {
    logic  valid;
    id_t   id;
    slot_t slot;
  } rel_sel_t;

endpackage

//--- hw/wrsp_id_lists.sv
// Per-ID linked lists of the bank, tracks reserved, filled and released slots in arrival order
`timescale 1ns/100ps

module wrsp_id_lists
  import wrsp_bank_pkg::*;
(
  input  logic               clk_i,
  input  logic               rst_ni,
  input  logic               res_fire_i,
  input  id_t                res_id_i,
  input  slot_t              res_slot_i,
  input  logic               in_valid_i,
  input  id_t                in_id_i,
  output logic               in_ready_o,
  output logic               fill_we_o,
  output slot_t              fill_slot_o,
  input  rel_sel_t           rel_sel_i,
  output slot_t [NumIds-1:0] tails_o,
  output logic  [NumIds-1:0] has_filled_o
);

  // Counts reach NumSlots, hence one extra bit
  typedef logic [SlotWidth:0] count_t;

  // Successor of each slot in its list
  slot_t  next_q [NumSlots];

  // Oldest filled, oldest empty and newest reserved slot per ID
  slot_t  tail_q [NumIds];
  slot_t  fill_q [NumIds];
  slot_t  head_q [NumIds];
  count_t n_filled_q [NumIds];
  count_t n_empty_q [NumIds];

  logic [NumIds-1:0] has_empty;
  logic [NumIds-1:0] list_busy;

  for (genvar i = 0; i < NumIds; i++) begin : g_id
    logic   res;
    logic   wr;
    logic   pop;
    count_t list_len;
    slot_t  tail_d;
    slot_t  fill_d;

    assign res = res_fire_i && (res_id_i == id_t'(i));
    assign wr = fill_we_o && (in_id_i == id_t'(i));
    assign pop = rel_sel_i.valid && (rel_sel_i.id == id_t'(i));
    assign list_len = n_filled_q[i] + n_empty_q[i];

    assign has_empty[i] = (n_empty_q[i] != '0);
    assign list_busy[i] = (list_len != '0);
    assign has_filled_o[i] = (n_filled_q[i] != '0);
    assign tails_o[i] = tail_q[i];

    // New slot becomes the tail when the list is or becomes empty this cycle
    always_comb begin
      if (res && (list_len == '0 || (pop && list_len == count_t'(1)))) begin
        tail_d = res_slot_i;
      end else if (pop) begin
        tail_d = next_q[tail_q[i]];
      end else begin
        tail_d = tail_q[i];
      end
    end

    // New slot becomes the fill pointer when no empty slot is left
    always_comb begin
      if (res && (n_empty_q[i] == '0 || (wr && n_empty_q[i] == count_t'(1)))) begin
        fill_d = res_slot_i;
      end else if (wr) begin
        fill_d = next_q[fill_q[i]];
      end else begin
        fill_d = fill_q[i];
      end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
        tail_q[i] <= '0;
        fill_q[i] <= '0;
        head_q[i] <= '0;
        n_filled_q[i] <= '0;
        n_empty_q[i] <= '0;
      end else begin
        tail_q[i] <= tail_d;
        fill_q[i] <= fill_d;
        if (res) begin
          head_q[i] <= res_slot_i;
        end
        n_filled_q[i] <= n_filled_q[i] + count_t'(wr) - count_t'(pop);
        n_empty_q[i] <= n_empty_q[i] + count_t'(res) - count_t'(wr);
      end
    end
  end

  // Link the new slot behind the current head
  // The head of an empty list may belong to another ID by now, so skip it
  always_ff @(posedge clk_i) begin
    if (res_fire_i && list_busy[res_id_i]) begin
      next_q[head_q[res_id_i]] <= res_slot_i;
    end
  end

  // Fill side
  assign in_ready_o = has_empty[in_id_i];
  assign fill_we_o = in_valid_i && in_ready_o;
  assign fill_slot_o = fill_q[in_id_i];

endmodule

//--- hw/wrsp_release_arbiter.sv
// Release arbiter of the bank, picks the lowest eligible ID and holds the one-entry output stage
`timescale 1ns/100ps

module wrsp_release_arbiter
  import wrsp_bank_pkg::*;
(
  input  logic               clk_i,
  input  logic               rst_ni,
  input  slot_t [NumIds-1:0] tails_i,
  input  logic  [NumIds-1:0] has_filled_i,
  input  slot_mask_t         release_en_i,
  input  logic               out_ready_i,
  output rel_sel_t           rel_sel_o,
  output logic               rd_en_o,
  output slot_t              rd_slot_o,
  output logic               out_valid_o,
  output slot_mask_t         released_o
);

  logic [NumIds-1:0] eligible;
  logic              stage_free;
  logic              out_valid_q;
  slot_mask_t        inflight_q;
  id_t               sel_id;

  // An ID may leave only through its oldest filled slot
  for (genvar i = 0; i < NumIds; i++) begin : g_elig
    assign eligible[i] = has_filled_i[i] && release_en_i[tails_i[i]];
  end

  always_comb begin
    sel_id = '0;
    for (int i = NumIds - 1; i >= 0; i--) begin
      if (eligible[i]) begin
        sel_id = id_t'(i);
      end
    end
  end

  // Stage accepts a new response when empty or draining
  assign stage_free = !out_valid_q || out_ready_i;

  assign rel_sel_o.valid = stage_free && (|eligible);
  assign rel_sel_o.id = sel_id;
  assign rel_sel_o.slot = tails_i[sel_id];

  assign rd_en_o = rel_sel_o.valid;
  assign rd_slot_o = rel_sel_o.slot;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      out_valid_q <= 1'b0;
    end else if (stage_free) begin
      out_valid_q <= rel_sel_o.valid;
    end
  end

  // Slot of the response in flight, one-hot
  always_ff @(posedge clk_i) begin
    if (rel_sel_o.valid) begin
      inflight_q <= slot_mask_t'(1) << rel_sel_o.slot;
    end
  end

  assign out_valid_o = out_valid_q;
  assign released_o = (out_valid_q && out_ready_i) ? inflight_q : '0;

endmodule

//--- hw/wrsp_slot_alloc.sv
// Slot occupancy tracking of the bank, offers the lowest free slot to the reservation port
`timescale 1ns/100ps

module wrsp_slot_alloc
  import wrsp_bank_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_ni,
  input  logic       res_fire_i,
  input  slot_mask_t released_i,
  output slot_t      free_slot_o,
  output logic       any_free_o
);

  slot_mask_t occ_q;
  slot_mask_t occ_d;
  slot_mask_t res_mask;

  // Lowest clear bit wins
  always_comb begin
    free_slot_o = '0;
    for (int s = NumSlots - 1; s >= 0; s--) begin
      if (!occ_q[s]) begin
        free_slot_o = slot_t'(s);
      end
    end
  end

  assign any_free_o = ~&occ_q;

  // The reserved slot is always free and the released one always occupied,
  // so the two masks never touch the same bit
  assign res_mask = slot_mask_t'(res_fire_i) << free_slot_o;
  assign occ_d = (occ_q | res_mask) & ~released_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      occ_q <= '0;
    end else begin
      occ_q <= occ_d;
    end
  end

endmodule

//--- hw/wrsp_slot_ram.sv
// Message storage of the bank, one write port for fills and one registered read port for release
`timescale 1ns/100ps

module wrsp_slot_ram
  import wrsp_bank_pkg::*;
(
  input  logic  clk_i,
  input  logic  we_i,
  input  slot_t waddr_i,
  input  msg_t  wdata_i,
  input  logic  re_i,
  input  slot_t raddr_i,
  output msg_t  rdata_o
);

  msg_t mem_q [NumSlots];

  // Write port
  always_ff @(posedge clk_i) begin
    if (we_i) begin
      mem_q[waddr_i] <= wdata_i;
    end
  end

  // Read data holds until the next read
  always_ff @(posedge clk_i) begin
    if (re_i) begin
      rdata_o <= mem_q[raddr_i];
    end
  end

endmodule

//--- verif/tb_wrsp_tasks.svh
// Drive, compare and directed test tasks of the bank testbench, included inside tb_wrsp_bank
`ifndef TB_WRSP_TASKS_SVH
`define TB_WRSP_TASKS_SVH

// Tasks start and end in the drive window just after a rising edge
task automatic next_cycle();
  @(posedge clk_i);
  #DriveDelay;
endtask

task automatic compare_msg(input string name, input msg_t got, input msg_t exp);
  if (got !== exp) begin
    $display("error: %s got 0x%h expected 0x%h", name, got, exp);
    error_count++;
  end
endtask

task automatic compare_slot(input string name, input slot_t got, input slot_t exp);
  if (got !== exp) begin
    $display("error: %s got 0x%h expected 0x%h", name, got, exp);
    error_count++;
  end
endtask

task automatic compare_mask(input string name, input slot_mask_t got, input slot_mask_t exp);
  if (got !== exp) begin
    $display("error: %s got 0x%h expected 0x%h", name, got, exp);
    error_count++;
  end
endtask

task automatic compare_flag(input string name, input logic got, input logic exp);
  if (got !== exp) begin
    $display("error: %s got 0x%h expected 0x%h", name, got, exp);
    error_count++;
  end
endtask

task automatic report_test(input string name, input int errs_at_start);
  test_count++;
  if (error_count == errs_at_start) begin
    $display("%s: ok", name);
  end else begin
    failed_tests++;
    $display("%s: %0d errors", name, error_count - errs_at_start);
  end
endtask

function automatic msg_t make_msg(input id_t id);
  msg_t m;
  m.payload = PayloadWidth'($urandom);
  m.id = id;
  return m;
endfunction

task automatic reserve_slot(input id_t id, input slot_t exp_addr);
  res_id_i = id;
  res_ready_i = 1'b1;
  @(negedge clk_i);
  compare_flag("res_valid_o", res_valid_o, 1'b1);
  compare_slot("res_addr_o", res_addr_o, exp_addr);
  next_cycle();
  res_ready_i = 1'b0;
endtask

task automatic write_msg(input msg_t msg);
  data_i = msg;
  in_valid_i = 1'b1;
  @(negedge clk_i);
  compare_flag("in_ready_o", in_ready_o, 1'b1);
  next_cycle();
  in_valid_i = 1'b0;
endtask

task automatic probe_ready(input id_t id, input logic exp);
  data_i.id = id;
  in_valid_i = 1'b0;
  @(negedge clk_i);
  compare_flag("in_ready_o", in_ready_o, exp);
  next_cycle();
endtask

// Ends on the falling edge where out_valid_o was seen
task automatic wait_out_valid();
  int waited;
  waited = 0;
  @(negedge clk_i);
  while (!out_valid_o && waited < ResponseWait) begin
    @(negedge clk_i);
    waited++;
  end
  if (!out_valid_o) begin
    $display("no response appeared on out_valid_o within %0d cycles", ResponseWait);
    error_count++;
  end
endtask

task automatic expect_response(input msg_t exp_msg, input slot_t exp_slot);
  wait_out_valid();
  if (out_valid_o) begin
    compare_msg("data_o", data_o, exp_msg);
    compare_mask("released_o", released_o, slot_mask_t'(1) << exp_slot);
  end
  next_cycle();
endtask

task automatic idle_cycles(input int count);
  repeat (count) begin
    @(negedge clk_i);
    compare_flag("out_valid_o", out_valid_o, 1'b0);
    next_cycle();
  end
endtask

// Releases everything, all slots must come back free
task automatic drain_all(input int count);
  slot_mask_t freed;
  int seen;
  int waited;
  freed = '0;
  seen = 0;
  waited = 0;
  release_en_i = '1;
  out_ready_i = 1'b1;
  while (seen < count && waited < 4 * count) begin
    @(negedge clk_i);
    if (out_valid_o) begin
      if (!$onehot(released_o)) begin
        $display("error: released_o got 0x%h, not one-hot", released_o);
        error_count++;
      end
      freed |= released_o;
      seen++;
    end
    waited++;
  end
  next_cycle();
  release_en_i = '0;
  if (seen < count) begin
    $display("only %0d of %0d responses left the bank while draining", seen, count);
    error_count++;
  end
  compare_mask("freed slots", freed, '1);
endtask

task automatic check_reset_state();
  int errs;
  errs = error_count;
  @(negedge clk_i);
  compare_flag("res_valid_o", res_valid_o, 1'b1);
  compare_slot("res_addr_o", res_addr_o, '0);
  compare_flag("in_ready_o", in_ready_o, 1'b0);
  compare_flag("out_valid_o", out_valid_o, 1'b0);
  compare_mask("released_o", released_o, '0);
  next_cycle();
  report_test("reset state", errs);
endtask

task automatic allocate_lowest_free();
  msg_t m;
  int s;
  int errs;
  errs = error_count;
  // Slot s goes to ID s mod 4
  for (s = 0; s < NumSlots; s++) begin
    reserve_slot(id_t'(s), slot_t'(s));
  end
  @(negedge clk_i);
  compare_flag("res_valid_o", res_valid_o, 1'b0);
  next_cycle();
  // Slot 2 is the oldest of ID 2 and can leave on its own
  m = make_msg(id_t'(2));
  write_msg(m);
  out_ready_i = 1'b1;
  release_en_i = slot_mask_t'(1) << 2;
  expect_response(m, slot_t'(2));
  release_en_i = '0;
  reserve_slot(id_t'(2), slot_t'(2));
  for (s = 0; s < NumSlots; s++) begin
    write_msg(make_msg(id_t'(s)));
  end
  drain_all(NumSlots);
  report_test("lowest free allocation", errs);
endtask

task automatic keep_id_order();
  msg_t sent [3];
  int i;
  int errs;
  errs = error_count;
  for (i = 0; i < 3; i++) begin
    reserve_slot(id_t'(1), slot_t'(i));
  end
  probe_ready(id_t'(0), 1'b0);
  for (i = 0; i < 3; i++) begin
    sent[i] = make_msg(id_t'(1));
    write_msg(sent[i]);
  end
  probe_ready(id_t'(1), 1'b0);
  release_en_i = '1;
  out_ready_i = 1'b1;
  for (i = 0; i < 3; i++) begin
    expect_response(sent[i], slot_t'(i));
  end
  release_en_i = '0;
  report_test("order within an ID", errs);
endtask

task automatic gate_release();
  msg_t sent [3];
  int i;
  int errs;
  errs = error_count;
  for (i = 0; i < 3; i++) begin
    reserve_slot(id_t'(3), slot_t'(i));
  end
  for (i = 0; i < 3; i++) begin
    sent[i] = make_msg(id_t'(3));
    write_msg(sent[i]);
  end
  // Newest slot enabled, oldest not, so the ID stays put
  release_en_i = slot_mask_t'(1) << 2;
  idle_cycles(4);
  release_en_i = slot_mask_t'(5);
  expect_response(sent[0], slot_t'(0));
  // Slot 1 now blocks slot 2
  idle_cycles(3);
  release_en_i = slot_mask_t'(7);
  expect_response(sent[1], slot_t'(1));
  expect_response(sent[2], slot_t'(2));
  release_en_i = '0;
  report_test("release gating", errs);
endtask

task automatic arbitrate_with_backpressure();
  msg_t m0;
  msg_t m2;
  int errs;
  errs = error_count;
  reserve_slot(id_t'(2), slot_t'(0));
  reserve_slot(id_t'(0), slot_t'(1));
  m2 = make_msg(id_t'(2));
  m0 = make_msg(id_t'(0));
  write_msg(m2);
  write_msg(m0);
  out_ready_i = 1'b0;
  release_en_i = '1;
  wait_out_valid();
  repeat (4) begin
    compare_flag("out_valid_o", out_valid_o, 1'b1);
    compare_msg("data_o", data_o, m0);
    compare_mask("released_o", released_o, '0);
    @(negedge clk_i);
  end
  next_cycle();
  out_ready_i = 1'b1;
  expect_response(m0, slot_t'(1));
  expect_response(m2, slot_t'(0));
  release_en_i = '0;
  report_test("arbitration and back-pressure", errs);
endtask

`endif

//--- verif/tb_wrsp_bank.sv
// Directed testbench of the write-response bank, compiled from verilog.f with tb_wrsp_bank as top
`timescale 1ns/100ps

module tb_wrsp_bank
  import wrsp_bank_pkg::*;
();

  localparam time HalfPeriod = 10;
  localparam time DriveDelay = 2;
  localparam int ResetCycles = 8;
  localparam int ResponseWait = 20;
  localparam int unsigned Seed = 32'hca98_bee0;

  // Rough length of the whole sequence with every bounded wait used up
  localparam int SeqCycles = 500;
  localparam int MaxCycles = 4 * SeqCycles;

  logic       clk_i = 1'b0;
  logic       rst_ni;
  id_t        res_id_i;
  logic       res_ready_i;
  logic       res_valid_o;
  slot_t      res_addr_o;
  msg_t       data_i;
  logic       in_valid_i;
  logic       in_ready_o;
  slot_mask_t release_en_i;
  msg_t       data_o;
  logic       out_valid_o;
  logic       out_ready_i;
  slot_mask_t released_o;

  int error_count = 0;
  int test_count = 0;
  int failed_tests = 0;
  int cycle_count = 0;

  always #HalfPeriod clk_i = ~clk_i;

  wrsp_bank wrsp_bank_inst (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .res_id_i     (res_id_i),
    .res_ready_i  (res_ready_i),
    .res_valid_o  (res_valid_o),
    .res_addr_o   (res_addr_o),
    .data_i       (data_i),
    .in_valid_i   (in_valid_i),
    .in_ready_o   (in_ready_o),
    .release_en_i (release_en_i),
    .data_o       (data_o),
    .out_valid_o  (out_valid_o),
    .out_ready_i  (out_ready_i),
    .released_o   (released_o)
  );

  `include "tb_wrsp_tasks.svh"

  // Ends a run that stalls somewhere in the sequence
  always @(posedge clk_i) begin
    cycle_count++;
    if (cycle_count >= MaxCycles) begin
      $display("run stopped at the cycle limit of %0d cycles", MaxCycles);
      $display("Regression failed");
      $finish;
    end
  end

  initial begin
    void'($urandom(Seed));
    rst_ni = 1'b0;
    res_id_i = '0;
    res_ready_i = 1'b0;
    data_i = '0;
    in_valid_i = 1'b0;
    release_en_i = '0;
    out_ready_i = 1'b0;
    repeat (ResetCycles) @(posedge clk_i);
    #DriveDelay;
    rst_ni = 1'b1;

    check_reset_state();
    allocate_lowest_free();
    keep_id_order();
    gate_release();
    arbitrate_with_backpressure();

    $display("tests: %0d run, %0d failing, %0d errors", test_count, failed_tests, error_count);
    if (error_count == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

//--- verilog.f
+incdir+verif
hw/wrsp_bank_pkg.sv
hw/wrsp_slot_ram.sv
hw/wrsp_slot_alloc.sv
hw/wrsp_id_lists.sv
hw/wrsp_release_arbiter.sv
hw/wrsp_bank.sv
verif/tb_wrsp_bank.sv
